//--- src/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // geometry of the 1 KB two-way cache
    localparam int LINE_BYTES = 32;
    localparam int SET_COUNT  = 16;
    localparam int WAY_COUNT  = 2;
    localparam int BEAT_COUNT = 4;

    // address split: tag | index | offset
    localparam int OFFSET_W = 5;
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 23;

    typedef logic [31:0]               addr_t;
    typedef logic [63:0]               word_t;
    typedef logic [7:0]                wmask_t;
    typedef logic [LINE_BYTES*8-1:0]   line_t;
    typedef logic [LINE_BYTES-1:0]     line_mask_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [OFFSET_W-1:0]       offset_t;
    typedef logic [1:0]                beat_t;

    typedef struct packed {
        logic   rd;
        logic   wr;
        addr_t  addr;
        word_t  wdata;
        wmask_t wmask;
    } cpu_req_t;

    // read response beat from memory
    typedef struct packed {
        logic  valid;
        logic  last;
        word_t data;
    } mem_rd_t;

    // write beat towards memory
    typedef struct packed {
        logic  valid;
        logic  last;
        word_t data;
    } mem_wr_t;

endpackage

`default_nettype wire

//--- src/dcache_req_capture.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_req_capture
    import dcache_pkg::*;
(
    input  logic     I_clk,
    input  logic     I_rst,
    input  cpu_req_t cpu_req,
    input  logic     ready,
    output cpu_req_t held,
    output tag_t     look_tag,
    output index_t   look_index
);

    logic accept;

    assign accept = ready && (cpu_req.rd || cpu_req.wr);

    // live fields, looked up in the cycle the request shows up
    assign look_tag   = cpu_req.addr[31 -: TAG_W];
    assign look_index = cpu_req.addr[OFFSET_W +: INDEX_W];

    // request register, loaded on acceptance
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            held.rd <= 1'b0;
            held.wr <= 1'b0;
        end else if (accept) begin
            held <= cpu_req;
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store
    import dcache_pkg::*;
(
    input  logic   I_clk,
    input  logic   I_rst,
    input  tag_t   look_tag,
    input  index_t look_index,
    input  index_t fill_index,
    input  tag_t   fill_tag,
    input  logic   victim_way,
    input  logic   tag_fill,
    input  logic   tag_mark_dirty,
    input  logic   tag_clean,
    output logic   hit,
    output logic   hit_way,
    output logic   pick_way,
    output logic   victim_dirty,
    output tag_t   victim_tag
);

    tag_t                               tags [WAY_COUNT][SET_COUNT];
    logic [WAY_COUNT-1:0][SET_COUNT-1:0] valid_q;
    logic [WAY_COUNT-1:0][SET_COUNT-1:0] dirty_q;
    logic [WAY_COUNT-1:0]               way_hit;

    always_comb begin
        for (int w = 0; w < WAY_COUNT; w++) begin
            way_hit[w] = valid_q[w][look_index] && (tags[w][look_index] == look_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // way 1 on a way-1 hit, or when only way 0 of the set is filled
    assign pick_way = way_hit[1]
                   || (!hit && valid_q[0][look_index] && !valid_q[1][look_index]);

    // victim info, seen from the held request
    assign victim_dirty = dirty_q[victim_way][fill_index];
    assign victim_tag   = tags[victim_way][fill_index];

    always_ff @(posedge I_clk) begin
        if (tag_fill) begin
            tags[victim_way][fill_index] <= fill_tag;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (tag_fill) begin
                valid_q[victim_way][fill_index] <= 1'b1;
            end
            if (tag_mark_dirty) begin
                dirty_q[victim_way][fill_index] <= 1'b1;
            end else if (tag_clean) begin
                dirty_q[victim_way][fill_index] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array
    import dcache_pkg::*;
(
    input  logic       I_clk,
    input  logic       I_rst,
    input  index_t     index,
    input  logic       way,
    input  logic       rd_en,
    input  logic       wr_en,
    input  line_t      wr_line,
    input  line_mask_t wr_mask,
    output line_t      rd_line
);

    line_t mem_q [WAY_COUNT][SET_COUNT];

    // byte-masked line write
    always_ff @(posedge I_clk) begin
        if (wr_en) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (wr_mask[i]) begin
                    mem_q[way][index][i*8 +: 8] <= wr_line[i*8 +: 8];
                end
            end
        end
    end

    // registered read, held until the next rd_en
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            rd_line <= '0;
        end else if (rd_en) begin
            rd_line <= mem_q[way][index];
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl_fsm
    import dcache_pkg::*;
(
    input  logic       I_clk,
    input  logic       I_rst,
    input  cpu_req_t   cpu_req,
    input  cpu_req_t   held,
    input  logic       hit,
    input  logic       hit_way,
    input  logic       pick_way,
    input  logic       victim_dirty,
    input  logic       line_ready,
    input  line_t      fill_line,
    input  logic       wb_done,
    input  line_t      rd_line,
    output logic       ready,
    output logic       rd_valid,
    output word_t      rd_data,
    output logic       wr_done,
    output logic       tag_fill,
    output logic       tag_mark_dirty,
    output logic       tag_clean,
    output index_t     arr_index,
    output logic       arr_way,
    output logic       arr_rd_en,
    output logic       arr_wr_en,
    output line_t      arr_wr_line,
    output line_mask_t arr_wr_mask,
    output logic       miss_start,
    output logic       wb_start,
    output logic       victim_way
);

    typedef enum logic [2:0] {
        S_IDLE, S_RD_HIT, S_WR_HIT, S_MISS, S_REFILL, S_WB, S_ALLOC
    } state_t;

    state_t     state;
    state_t     next_state;
    state_t     prev_state;
    logic       accept;
    logic       way_q;
    offset_t    live_off;
    offset_t    held_off;
    line_mask_t held_mask;
    line_t      line_buf;
    line_t      out_line;

    // byte enables of one 64-bit word inside a line
    function automatic line_mask_t word_mask(input beat_t b, input wmask_t m);
        return line_mask_t'(m) << {b, 3'b000};
    endfunction

    function automatic line_t merge_line(input line_t base, input word_t data,
                                         input line_mask_t mask);
        line_t res;
        res = base;
        for (int i = 0; i < LINE_BYTES; i++) begin
            if (mask[i]) begin
                res[i*8 +: 8] = data[(i % 8)*8 +: 8];
            end
        end
        return res;
    endfunction

    assign live_off  = cpu_req.addr[OFFSET_W-1:0];
    assign held_off  = held.addr[OFFSET_W-1:0];
    assign held_mask = (held.wr && !held.rd) ? word_mask(held_off[4:3], held.wmask) : '0;

    assign ready  = (state == S_IDLE) || (state == S_RD_HIT) || (state == S_WR_HIT);
    assign accept = ready && (cpu_req.rd || cpu_req.wr);

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state      <= S_IDLE;
            prev_state <= S_IDLE;
        end else begin
            state      <= next_state;
            prev_state <= state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE, S_RD_HIT, S_WR_HIT: begin
                if (!accept)
                    next_state = S_IDLE;
                else if (!hit)
                    next_state = S_MISS;
                else
                    next_state = cpu_req.rd ? S_RD_HIT : S_WR_HIT;
            end
            S_MISS:   next_state = S_REFILL;
            S_REFILL: if (line_ready) next_state = victim_dirty ? S_WB : S_ALLOC;
            S_WB:     if (wb_done) next_state = S_ALLOC;
            S_ALLOC:  next_state = held.rd ? S_RD_HIT : S_WR_HIT;
            default:  next_state = S_IDLE;
        endcase
    end

    // way chosen at lookup time, kept for the whole miss
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            way_q <= 1'b0;
        end else if (accept) begin
            way_q <= pick_way;
        end
    end

    // refilled line with the pending cpu write merged in
    always_ff @(posedge I_clk) begin
        if (state == S_REFILL && line_ready) begin
            line_buf <= merge_line(fill_line, held.wdata, held_mask);
        end
    end

    //////////////////////////////////////////////////
    // data array and tag controls
    //////////////////////////////////////////////////
    // hits use the live request, MISS reads out the victim line for write-back
    assign arr_index = accept ? cpu_req.addr[OFFSET_W +: INDEX_W]
                              : held.addr[OFFSET_W +: INDEX_W];
    assign arr_way     = accept ? hit_way : way_q;
    assign arr_rd_en   = (accept && cpu_req.rd && hit) || (state == S_MISS);
    assign arr_wr_en   = (accept && !cpu_req.rd && hit) || (state == S_ALLOC);
    assign arr_wr_line = (state == S_ALLOC) ? line_buf : {BEAT_COUNT{cpu_req.wdata}};
    assign arr_wr_mask = (state == S_ALLOC) ? '1 : word_mask(live_off[4:3], cpu_req.wmask);

    assign tag_fill       = state == S_ALLOC;
    assign tag_mark_dirty = state == S_WR_HIT;
    assign tag_clean      = (state == S_WB) && wb_done;
    assign miss_start     = state == S_MISS;
    assign wb_start       = (state == S_WB) && (prev_state != S_WB);
    assign victim_way     = way_q;

    // cpu answers, right after an allocation the line is still in line_buf
    assign out_line = (prev_state == S_ALLOC) ? line_buf : rd_line;
    assign rd_valid = state == S_RD_HIT;
    assign rd_data  = out_line[{held_off[4:3], 6'd0} +: 64];
    assign wr_done  = state == S_WR_HIT;

endmodule

`default_nettype wire

//--- src/dcache_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_port
    import dcache_pkg::*;
(
    input  logic     I_clk,
    input  logic     I_rst,
    input  cpu_req_t held,
    input  tag_t     victim_tag,
    input  logic     miss_start,
    input  logic     wb_start,
    input  line_t    wb_line,
    input  mem_rd_t  mem_r,
    input  logic     ar_ready,
    input  logic     aw_ready,
    input  logic     w_ready,
    input  logic     b_valid,
    output logic     ar_valid,
    output addr_t    ar_addr,
    output logic     aw_valid,
    output addr_t    aw_addr,
    output mem_wr_t  mem_w,
    output line_t    fill_line,
    output logic     line_ready,
    output logic     wb_done
);

    typedef enum logic [1:0] {WB_IDLE, WB_ADDR, WB_DATA, WB_RESP} wb_state_t;

    wb_state_t wb_state;
    beat_t     beat;

    //////////////////////////////////////////////////
    // refill
    //////////////////////////////////////////////////
    assign ar_addr = {held.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            ar_valid <= 1'b0;
        end else if (miss_start) begin
            ar_valid <= 1'b1;
        end else if (ar_ready) begin
            ar_valid <= 1'b0;
        end
    end

    // beats arrive lowest first, shift them down from the top
    always_ff @(posedge I_clk) begin
        if (mem_r.valid) begin
            fill_line <= {mem_r.data, fill_line[LINE_BYTES*8-1:64]};
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst)
            line_ready <= 1'b0;
        else
            line_ready <= mem_r.valid && mem_r.last;
    end

    //////////////////////////////////////////////////
    // write-back sequencer
    //////////////////////////////////////////////////
    assign aw_valid = wb_state == WB_ADDR;
    assign aw_addr  = {victim_tag, held.addr[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}};

    assign mem_w.valid = wb_state == WB_DATA;
    assign mem_w.last  = (wb_state == WB_DATA) && (beat == beat_t'(BEAT_COUNT - 1));
    assign mem_w.data  = wb_line[{beat, 6'd0} +: 64];

    assign wb_done = b_valid && (wb_state == WB_RESP);

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            wb_state <= WB_IDLE;
            beat     <= '0;
        end else begin
            case (wb_state)
                WB_IDLE: if (wb_start) wb_state <= WB_ADDR;
                WB_ADDR: begin
                    if (aw_ready) begin
                        wb_state <= WB_DATA;
                        beat     <= '0;
                    end
                end
                WB_DATA: begin
                    if (w_ready) begin
                        beat <= beat + 1'b1;
                        if (mem_w.last)
                            wb_state <= WB_RESP;
                    end
                end
                WB_RESP: if (b_valid) wb_state <= WB_IDLE;
                default: wb_state <= WB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  logic     I_clk,
    input  logic     I_rst,
    // cpu side
    input  cpu_req_t cpu_req,
    output logic     ready,
    output logic     rd_valid,
    output word_t    rd_data,
    output logic     wr_done,
    // memory bus
    input  mem_rd_t  mem_r,
    input  logic     ar_ready,
    input  logic     aw_ready,
    input  logic     w_ready,
    input  logic     b_valid,
    output logic     ar_valid,
    output addr_t    ar_addr,
    output logic     aw_valid,
    output addr_t    aw_addr,
    output mem_wr_t  mem_w
);

    cpu_req_t   held;
    tag_t       look_tag;
    index_t     look_index;
    logic       hit;
    logic       hit_way;
    logic       pick_way;
    logic       victim_dirty;
    tag_t       victim_tag;
    logic       victim_way;
    logic       tag_fill;
    logic       tag_mark_dirty;
    logic       tag_clean;
    index_t     arr_index;
    logic       arr_way;
    logic       arr_rd_en;
    logic       arr_wr_en;
    line_t      arr_wr_line;
    line_mask_t arr_wr_mask;
    line_t      rd_line;
    line_t      fill_line;
    logic       line_ready;
    logic       wb_done;
    logic       miss_start;
    logic       wb_start;

    dcache_req_capture u_capture (
        .I_clk      (I_clk),
        .I_rst      (I_rst),
        .cpu_req    (cpu_req),
        .ready      (ready),
        .held       (held),
        .look_tag   (look_tag),
        .look_index (look_index)
    );

    dcache_tag_store u_tags (
        .I_clk          (I_clk),
        .I_rst          (I_rst),
        .look_tag       (look_tag),
        .look_index     (look_index),
        .fill_index     (held.addr[OFFSET_W +: INDEX_W]),
        .fill_tag       (held.addr[31 -: TAG_W]),
        .victim_way     (victim_way),
        .tag_fill       (tag_fill),
        .tag_mark_dirty (tag_mark_dirty),
        .tag_clean      (tag_clean),
        .hit            (hit),
        .hit_way        (hit_way),
        .pick_way       (pick_way),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag)
    );

    dcache_data_array u_data (
        .I_clk   (I_clk),
        .I_rst   (I_rst),
        .index   (arr_index),
        .way     (arr_way),
        .rd_en   (arr_rd_en),
        .wr_en   (arr_wr_en),
        .wr_line (arr_wr_line),
        .wr_mask (arr_wr_mask),
        .rd_line (rd_line)
    );

    dcache_ctrl_fsm u_ctrl (
        .I_clk          (I_clk),
        .I_rst          (I_rst),
        .cpu_req        (cpu_req),
        .held           (held),
        .hit            (hit),
        .hit_way        (hit_way),
        .pick_way       (pick_way),
        .victim_dirty   (victim_dirty),
        .line_ready     (line_ready),
        .fill_line      (fill_line),
        .wb_done        (wb_done),
        .rd_line        (rd_line),
        .ready          (ready),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .wr_done        (wr_done),
        .tag_fill       (tag_fill),
        .tag_mark_dirty (tag_mark_dirty),
        .tag_clean      (tag_clean),
        .arr_index      (arr_index),
        .arr_way        (arr_way),
        .arr_rd_en      (arr_rd_en),
        .arr_wr_en      (arr_wr_en),
        .arr_wr_line    (arr_wr_line),
        .arr_wr_mask    (arr_wr_mask),
        .miss_start     (miss_start),
        .wb_start       (wb_start),
        .victim_way     (victim_way)
    );

    // victim line comes straight from the array read port
    dcache_mem_port u_mem (
        .I_clk      (I_clk),
        .I_rst      (I_rst),
        .held       (held),
        .victim_tag (victim_tag),
        .miss_start (miss_start),
        .wb_start   (wb_start),
        .wb_line    (rd_line),
        .mem_r      (mem_r),
        .ar_ready   (ar_ready),
        .aw_ready   (aw_ready),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .ar_valid   (ar_valid),
        .ar_addr    (ar_addr),
        .aw_valid   (aw_valid),
        .aw_addr    (aw_addr),
        .mem_w      (mem_w),
        .fill_line  (fill_line),
        .line_ready (line_ready),
        .wb_done    (wb_done)
    );

endmodule

`default_nettype wire

//--- testbench/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    localparam int          CLK_HALF = 10;
    localparam int unsigned SEED     = 32'h3bf4;

    typedef struct packed {
        int         test_no;
        logic [1:0] op;
        addr_t      addr;
        word_t      wdata;
        wmask_t     wmask;
        word_t      expect_data;
    } trace_entry_t;

    logic     I_clk;
    logic     I_rst;
    cpu_req_t cpu_req;
    logic     ready;
    logic     rd_valid;
    word_t    rd_data;
    logic     wr_done;
    mem_rd_t  mem_r;
    logic     ar_ready;
    logic     aw_ready;
    logic     w_ready;
    logic     b_valid;
    logic     ar_valid;
    addr_t    ar_addr;
    logic     aw_valid;
    addr_t    aw_addr;
    mem_wr_t  mem_w;

    word_t        mem_words [addr_t];
    trace_entry_t trace_q [$];
    int           check_count = 0;
    int           error_count = 0;
    int           test_count  = 0;
    int           test_checks = 0;
    int           test_errors = 0;
    int           cycles      = 0;
    int           cycle_limit = 0;

    dcache_top DUT (
        .I_clk    (I_clk),
        .I_rst    (I_rst),
        .cpu_req  (cpu_req),
        .ready    (ready),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .wr_done  (wr_done),
        .mem_r    (mem_r),
        .ar_ready (ar_ready),
        .aw_ready (aw_ready),
        .w_ready  (w_ready),
        .b_valid  (b_valid),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .aw_valid (aw_valid),
        .aw_addr  (aw_addr),
        .mem_w    (mem_w)
    );

    initial begin
        I_clk = 1'b0;
        forever #CLK_HALF I_clk = ~I_clk;
    end

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////
    // unwritten words hold the word address on top and its inverse below
    function automatic word_t pattern_word(input addr_t wa);
        return {wa, ~wa};
    endfunction

    function automatic word_t fetch_word(input addr_t byte_addr);
        addr_t wa;
        wa = byte_addr >> 3;
        if (mem_words.exists(wa))
            return mem_words[wa];
        else
            return pattern_word(wa);
    endfunction

    // refill beats go out lowest first with short random gaps
    initial begin
        int    delay;
        addr_t base;
        ar_ready = 1'b0;
        mem_r    = '0;
        forever begin
            @(negedge I_clk);
            if (ar_valid) begin
                delay = $urandom % 4;
                repeat (delay) @(negedge I_clk);
                ar_ready = 1'b1;
                base     = ar_addr;
                @(negedge I_clk);
                ar_ready = 1'b0;
                for (int b = 0; b < BEAT_COUNT; b++) begin
                    mem_r.valid = 1'b1;
                    mem_r.last  = (b == BEAT_COUNT - 1);
                    mem_r.data  = fetch_word(base + addr_t'(b * 8));
                    @(negedge I_clk);
                    mem_r = '0;
                    delay = $urandom % 2;
                    repeat (delay) @(negedge I_clk);
                end
            end
        end
    end

    // write-back beats land in memory with all bytes enabled
    initial begin
        int    delay;
        addr_t base;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        forever begin
            @(negedge I_clk);
            if (aw_valid) begin
                delay = $urandom % 4;
                repeat (delay) @(negedge I_clk);
                aw_ready = 1'b1;
                base     = aw_addr;
                @(negedge I_clk);
                aw_ready = 1'b0;
                for (int b = 0; b < BEAT_COUNT; b++) begin
                    while (!mem_w.valid) begin
                        @(negedge I_clk);
                    end
                    delay = $urandom % 4;
                    repeat (delay) @(negedge I_clk);
                    w_ready = 1'b1;
                    check_count++;
                    if (mem_w.last !== (b == BEAT_COUNT - 1)) begin
                        report_mismatch("mem_w.last", word_t'(mem_w.last),
                                        word_t'(b == BEAT_COUNT - 1));
                    end
                    mem_words[(base >> 3) + addr_t'(b)] = mem_w.data;
                    @(negedge I_clk);
                    w_ready = 1'b0;
                end
                b_valid = 1'b1;
                @(negedge I_clk);
                b_valid = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////
    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        error_count++;
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic flag_problem(input string msg);
        error_count++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic close_test(input int test_no);
        $display("test %0d done: %0d checks, %0d errors", test_no,
                 check_count - test_checks, error_count - test_errors);
        test_count++;
        test_checks = check_count;
        test_errors = error_count;
    endtask

    // one trace request from issue to its ending strobe
    task automatic run_request(input trace_entry_t e);
        logic is_wr;
        logic must_hit;
        logic done;
        int   latency;
        is_wr    = e.op[0];
        must_hit = e.op[1];
        @(negedge I_clk);
        check_count++;
        if (rd_valid || wr_done) begin
            flag_problem($sformatf("strobe high with no request pending before %h", e.addr));
        end
        while (!ready) begin
            @(negedge I_clk);
        end
        cpu_req.rd    = !is_wr;
        cpu_req.wr    = is_wr;
        cpu_req.addr  = e.addr;
        cpu_req.wdata = e.wdata;
        cpu_req.wmask = e.wmask;
        @(negedge I_clk);
        cpu_req.rd = 1'b0;
        cpu_req.wr = 1'b0;
        latency    = 1;
        done       = 1'b0;
        while (!done) begin
            if (is_wr ? wr_done : rd_valid) begin
                done = 1'b1;
            end else begin
                if (ready) begin
                    flag_problem($sformatf("ready high while request to %h is pending",
                                           e.addr));
                end
                @(negedge I_clk);
                latency++;
            end
        end
        check_count++;
        if (!ready) begin
            flag_problem($sformatf("ready low in the ending cycle of request to %h", e.addr));
        end
        if (must_hit) begin
            check_count++;
            if (latency != 1) begin
                flag_problem($sformatf("hit at %h took %0d cycles instead of 1",
                                       e.addr, latency));
            end
        end
        if (!is_wr) begin
            check_count++;
            if (rd_data !== e.expect_data) begin
                report_mismatch("rd_data", rd_data, e.expect_data);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // run limit
    //////////////////////////////////////////////////
    initial begin
        while (cycle_limit == 0 || cycles < cycle_limit) begin
            @(posedge I_clk);
            cycles++;
        end
        $display("ERROR: run stopped after %0d cycles, a request never finished", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int           fd;
        int           n;
        int           t_no;
        int           op_v;
        addr_t        a_v;
        word_t        wd_v;
        wmask_t       wm_v;
        word_t        ex_v;
        string        line;
        int           current_test;
        trace_entry_t e;
        void'($urandom(SEED));
        cpu_req = '0;
        I_rst   = 1'b1;

        fd = $fopen("testbench/dcache_trace.txt", "r");
        if (fd == 0) begin
            flag_problem("could not open testbench/dcache_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %h %h %h %h", t_no, op_v, a_v, wd_v, wm_v, ex_v);
                    if (n == 6) begin
                        e.test_no     = t_no;
                        e.op          = op_v[1:0];
                        e.addr        = a_v;
                        e.wdata       = wd_v;
                        e.wmask       = wm_v;
                        e.expect_data = ex_v;
                        trace_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
            if (trace_q.size() == 0) begin
                flag_problem("the trace file holds no requests");
            end
        end
        cycle_limit = 64 * trace_q.size() + 100;

        repeat (2) @(posedge I_clk);
        @(negedge I_clk);
        I_rst = 1'b0;

        // test 1 checks the outputs straight after reset
        check_count += 6;
        if (ready !== 1'b1)
            report_mismatch("ready", word_t'(ready), 64'd1);
        if (rd_valid !== 1'b0)
            report_mismatch("rd_valid", word_t'(rd_valid), 64'd0);
        if (wr_done !== 1'b0)
            report_mismatch("wr_done", word_t'(wr_done), 64'd0);
        if (ar_valid !== 1'b0)
            report_mismatch("ar_valid", word_t'(ar_valid), 64'd0);
        if (aw_valid !== 1'b0)
            report_mismatch("aw_valid", word_t'(aw_valid), 64'd0);
        if (mem_w.valid !== 1'b0)
            report_mismatch("mem_w.valid", word_t'(mem_w.valid), 64'd0);
        close_test(1);

        // trace tests grouped by test number
        current_test = 0;
        if (trace_q.size() > 0) begin
            current_test = trace_q[0].test_no;
        end
        foreach (trace_q[i]) begin
            if (trace_q[i].test_no != current_test) begin
                close_test(current_test);
                current_test = trace_q[i].test_no;
            end
            run_request(trace_q[i]);
        end
        if (trace_q.size() > 0) begin
            close_test(current_test);
        end

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/dcache_pkg.sv
src/dcache_req_capture.sv
src/dcache_tag_store.sv
src/dcache_data_array.sv
src/dcache_ctrl_fsm.sv
src/dcache_mem_port.sv
src/dcache_top.sv
testbench/dcache_tb.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= dcache_tb
LINT_TOP    ?= dcache_top
FILELIST    ?= sources.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing
BUILD_FLAGS ?= --binary -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "=== PASS ==="

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/dcache_trace.txt
# columns: test op addr wdata wmask expected_rdata (test and op decimal, the rest hex)
# op: 0 read, 1 write, 2 read that must hit, 3 write that must hit
2 0 00001008 0000000000000000 00 00000201fffffdfe
2 2 00001010 0000000000000000 00 00000202fffffdfd
2 2 00001000 0000000000000000 00 00000200fffffdff
3 3 00001018 1122334455667788 5a 0000000000000000
3 2 00001018 0000000000000000 00 0022024455ff77fc
4 1 00002028 deadbeefcafef00d f0 0000000000000000
4 2 00002028 0000000000000000 00 deadbeeffffffbfa
4 2 00002020 0000000000000000 00 00000404fffffbfb
5 1 00003040 0123456789abcdef ff 0000000000000000
5 0 00003248 0000000000000000 00 00000649fffff9b6
5 0 00003450 0000000000000000 00 0000068afffff975
5 2 00003248 0000000000000000 00 00000649fffff9b6
5 0 00003040 0000000000000000 00 0123456789abcdef
5 2 00003048 0000000000000000 00 00000609fffff9f6
6 1 00000068 a5a5a5a5a5a5a5a5 ff 0000000000000000
6 1 00000270 0000000012345678 0f 0000000000000000
6 0 00000460 0000000000000000 00 0000008cffffff73
6 0 00000068 0000000000000000 00 a5a5a5a5a5a5a5a5
6 2 00000270 0000000000000000 00 0000004e12345678
6 0 00000460 0000000000000000 00 0000008cffffff73
